/* mips_mem.f */
rtl/mips_mem_pkg.sv
rtl/cp0_regs.sv
rtl/mem_wb_reg.sv
rtl/except_arbiter.sv
rtl/mem_access_ctrl.sv
rtl/mips_mem_top.sv
dv/mips_mem_sva.sv
dv/tb_mips_mem.sv

/* run.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 \
    --top-module tb_mips_mem -f mips_mem.f -o tb_mips_mem \
    && ./obj_dir/tb_mips_mem \
    || exit 1

/* dv/tb_mips_mem.sv */
`timescale 1ns/1ps

module tb_mips_mem
    import mips_mem_pkg::*;
();

    localparam int N_LOADS    = 60;
    localparam int N_STORES   = 12;
    localparam int N_MIS      = 8;
    localparam int N_PRIO     = 24;
    localparam int N_OPS      = N_LOADS + 2 * N_STORES + N_MIS + N_PRIO + 8;
    localparam int MAX_CYCLES = 40 * N_OPS + 200;
    localparam int SLOW       = 6;

    logic        clk;
    logic        rst;
    mem_in_t     mem_in;
    bus_rsp_t    bus_rsp;
    logic [5:0]  hw_int;
    bus_req_t    bus_req;
    wb_t         wb;
    logic        stall;
    exc_code_e   exc_code;
    logic [31:0] epc;

    // responder memory and the expected image
    logic [31:0] mem [0:255];
    logic [31:0] img [0:255];
    wb_t         exp_q [$];
    int          n_checked = 0;
    logic [31:0] rng_drv = 32'd54381;
    logic [31:0] rng_bus = 32'd54381;
    string       cur_test = "reset";
    logic        cap = 1'b0;
    int          cycles = 0;
    int          force_delay;

    logic        phase;
    int          a_cnt;
    int          d_cnt;
    bus_req_t    lat;
    logic [31:0] rd_addr;

    mips_mem_top i_mips_mem_top (
        .clk        (clk),
        .rst        (rst),
        .mem_in_i   (mem_in),
        .bus_rsp_i  (bus_rsp),
        .hw_int_i   (hw_int),
        .bus_req_o  (bus_req),
        .wb_o       (wb),
        .stall_o    (stall),
        .exc_code_o (exc_code),
        .epc_o      (epc)
    );

    bind mem_access_ctrl mips_mem_sva i_mips_mem_sva (
        .clk       (clk),
        .rst       (rst),
        .bus_req_i (bus_req_o),
        .bus_rsp_i (bus_rsp_i),
        .stall_i   (stall_o)
    );

    initial begin
        clk = 1'b0;
    end

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic int drv_rand(input int n);
        rng_drv = lcg_step(rng_drv);
        return int'(rng_drv[31:16]) % n;
    endfunction

    function automatic logic [31:0] drv_word();
        logic [31:0] hi;
        rng_drv = lcg_step(rng_drv);
        hi      = {16'd0, rng_drv[31:16]};
        rng_drv = lcg_step(rng_drv);
        return {hi[15:0], rng_drv[31:16]};
    endfunction

    function automatic int bus_rand(input int n);
        rng_bus = lcg_step(rng_bus);
        return int'(rng_bus[31:16]) % n;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h9e37_79b9 * 32'(i + 1) ^ 32'(i << 20);
    endfunction

    function automatic logic is_store(input mem_op_e op);
        return op == OP_SB || op == OP_SH || op == OP_SW;
    endfunction

    function automatic logic misaligned(input mem_in_t m);
        case (m.op)
            OP_LH, OP_LHU, OP_SH: return m.addr[0];
            OP_LW, OP_SW:         return |m.addr[1:0];
            default:              return 1'b0;
        endcase
    endfunction

    // request as the bus should see it
    function automatic bus_req_t bus_expect(input mem_in_t m);
        bus_req_t r;
        r      = '0;
        r.req  = 1'b1;
        r.wr   = is_store(m.op);
        r.addr = {3'b000, m.addr[28:0]};
        case (m.op)
            OP_LB, OP_LBU, OP_SB: begin
                r.size  = 2'd0;
                r.wdata = {4{m.sdata[7:0]}};
            end
            OP_LH, OP_LHU, OP_SH: begin
                r.size  = 2'd1;
                r.wdata = {2{m.sdata[15:0]}};
            end
            default: begin
                r.size  = 2'd2;
                r.wdata = m.sdata;
            end
        endcase
        return r;
    endfunction

    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [31:0] addr);
        logic [31:0] word;
        logic [7:0]  b;
        logic [15:0] h;
        word = img[addr[9:2]];
        case (addr[1:0])
            2'd0:    b = word[7:0];
            2'd1:    b = word[15:8];
            2'd2:    b = word[23:16];
            default: b = word[31:24];
        endcase
        h = addr[1] ? word[31:16] : word[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'd0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    function automatic logic [31:0] store_merge(input logic [31:0] old, input mem_op_e op,
                                                input logic [1:0] lo, input logic [31:0] d);
        logic [31:0] w;
        w = old;
        if (op == OP_SB) begin
            case (lo)
                2'd0:    w[7:0]   = d[7:0];
                2'd1:    w[15:8]  = d[7:0];
                2'd2:    w[23:16] = d[7:0];
                default: w[31:24] = d[7:0];
            endcase
        end else if (op == OP_SH) begin
            if (lo[1]) begin
                w[31:16] = d[15:0];
            end else begin
                w[15:0] = d[15:0];
            end
        end else begin
            w = d;
        end
        return w;
    endfunction

    function automatic wb_t load_expect(input mem_in_t m);
        wb_t w;
        w       = '0;
        w.wreg  = 1'b1;
        w.wd    = m.wd;
        w.wdata = ref_load(m.op, m.addr);
        w.pc    = m.pc;
        return w;
    endfunction

    // exception priority, highest first
    function automatic exc_code_e exc_expect(input mem_in_t m, input logic int_pend);
        if (!m.valid) return EXC_NONE;
        if (int_pend) return EXC_INT;
        if (m.exc.syscall) return EXC_SYS;
        if (m.exc.brk) return EXC_BP;
        if (m.exc.ri) return EXC_RI;
        if (m.exc.ov) return EXC_OV;
        if (m.exc.trap) return EXC_TR;
        if (misaligned(m)) return is_store(m.op) ? EXC_ADES : EXC_ADEL;
        if (m.exc.eret) return EXC_ERET;
        return EXC_NONE;
    endfunction

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped after an error");
    endtask

    task automatic check_wb(input string name, input wb_t exp, input wb_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_exc(input string name, input exc_code_e exp, input exc_code_e act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_bus(input string name, input bus_req_t exp, input bus_req_t act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s expected %h actual %h", name, exp, act);
            stop_run();
        end
    endtask

    // drive one instruction and follow it until the stall ends
    task automatic run_op(input mem_in_t m, input exc_code_e exp_exc, input int min_stall = 0,
                          input logic chk_epc = 1'b0, input logic [31:0] exp_epc = '0);
        bus_req_t exp_req;
        logic     uses_bus;
        logic     busy;
        int       stalls;
        exp_req  = bus_expect(m);
        uses_bus = m.valid && m.op != OP_NONE && !misaligned(m);
        stalls   = 0;
        @(negedge clk);
        mem_in = m;
        @(posedge clk);
        check_exc(cur_test, exp_exc, exc_code);
        if (chk_epc) begin
            check_word(cur_test, exp_epc, epc);
        end
        if (uses_bus && !is_store(m.op)) begin
            exp_q.push_back(load_expect(m));
        end
        if (uses_bus) begin
            if (!bus_req.req) begin
                $display("error: %s issued no bus request for an aligned access", cur_test);
                stop_run();
            end
            do begin
                if (bus_req.req) begin
                    check_bus(cur_test, exp_req, bus_req);
                end
                busy = stall;
                if (busy) begin
                    stalls++;
                    @(posedge clk);
                end
            end while (busy);
            if (stalls < min_stall) begin
                $display("error: %s stalled %0d cycles, bus held it off longer", cur_test,
                         stalls);
                stop_run();
            end
        end else if (bus_req.req || stall) begin
            $display("error: %s raised a bus request or stall without a transfer", cur_test);
            stop_run();
        end
    endtask

    // bus responder with random addr_ok and data_ok delays
    initial begin : bus_responder
        bus_req_t    cur;
        bus_req_t    acc_req;
        logic [31:0] mask;
        logic        acc;
        logic        done;
        logic        wait_a;
        logic        wait_d;
        phase = 1'b0;
        a_cnt = 0;
        d_cnt = 0;
        lat   = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            @(posedge clk);
            acc     = 1'b0;
            done    = 1'b0;
            wait_a  = 1'b0;
            wait_d  = 1'b0;
            acc_req = bus_req;
            cur     = phase ? lat : bus_req;
            if (!rst) begin
                if (bus_rsp.data_ok) begin
                    done = 1'b1;
                    if (cur.wr) begin
                        case (cur.size)
                            2'd0:    mask = 32'hff << {cur.addr[1:0], 3'b000};
                            2'd1:    mask = cur.addr[1] ? 32'hffff_0000 : 32'h0000_ffff;
                            default: mask = 32'hffff_ffff;
                        endcase
                        mem[cur.addr[9:2]] = (mem[cur.addr[9:2]] & ~mask) | (cur.wdata & mask);
                    end
                end else if (bus_rsp.addr_ok) begin
                    acc = 1'b1;
                end else if (!phase && bus_req.req) begin
                    wait_a = 1'b1;
                end else if (phase) begin
                    wait_d = 1'b1;
                end
            end
            @(negedge clk);
            if (acc) begin
                phase = 1'b1;
                lat   = acc_req;
            end else if (wait_a) begin
                a_cnt--;
            end else if (wait_d) begin
                d_cnt--;
            end else begin
                // idle or finished, pick delays for the next request
                phase = 1'b0;
                if (force_delay > 0) begin
                    a_cnt = force_delay;
                    d_cnt = force_delay;
                end else begin
                    a_cnt = bus_rand(4);
                    d_cnt = bus_rand(4);
                end
            end
            if (done) begin
                phase = 1'b0;
            end
        end
    end

    assign rd_addr         = phase ? lat.addr : bus_req.addr;
    assign bus_rsp.rdata   = mem[rd_addr[9:2]];
    assign bus_rsp.addr_ok = !phase && bus_req.req && (a_cnt == 0);
    assign bus_rsp.data_ok = phase ? (d_cnt == 0) : (bus_req.req && a_cnt == 0 && d_cnt == 0);

    // a capture happened on the last edge
    always @(posedge clk) begin
        cap <= !rst && !stall;
    end

    always @(negedge clk) begin : wb_compare
        if (cap && wb.wreg) begin
            if (n_checked >= exp_q.size()) begin
                $display("error: %s wrote a register with no load pending", cur_test);
                stop_run();
            end else begin
                check_wb(cur_test, exp_q[n_checked], wb);
                n_checked++;
            end
        end
    end

    always @(posedge clk) begin : watchdog
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("error: run did not finish within %0d cycles", MAX_CYCLES);
            stop_run();
        end
    end

    initial begin : stimulus
        mem_in_t     m;
        mem_in_t     nop;
        logic [31:0] hi;
        logic [9:0]  off;
        int          pick;
        rst         = 1'b1;
        mem_in      = '0;
        hw_int      = '0;
        force_delay = 0;
        for (int i = 0; i < 256; i++) begin
            img[i] = fill_word(i);
        end
        repeat (8) @(negedge clk);
        rst = 1'b0;

        cur_test = "random_loads";
        for (int i = 0; i < N_LOADS; i++) begin
            m       = '0;
            m.valid = 1'b1;
            m.wreg  = 1'b1;
            m.wd    = 5'(drv_rand(31) + 1);
            m.pc    = 32'h0040_0000 + 32'(i * 4);
            m.sdata = drv_word();
            pick    = drv_rand(5);
            case (pick)
                0:       m.op = OP_LB;
                1:       m.op = OP_LBU;
                2:       m.op = OP_LH;
                3:       m.op = OP_LHU;
                default: m.op = OP_LW;
            endcase
            if (pick < 2) begin
                off = 10'(drv_rand(1024));
            end else if (pick < 4) begin
                off = 10'(drv_rand(512) * 2);
            end else begin
                off = 10'(drv_rand(256) * 4);
            end
            hi     = drv_word();
            m.addr = {hi[31:10], off};
            run_op(m, EXC_NONE);
        end

        cur_test = "store_then_load";
        for (int i = 0; i < N_STORES; i++) begin
            m       = '0;
            m.valid = 1'b1;
            m.wreg  = 1'b1;
            m.wd    = 5'(drv_rand(31) + 1);
            m.pc    = 32'h0041_0000 + 32'(i * 8);
            m.sdata = drv_word();
            pick    = drv_rand(3);
            m.op    = pick == 0 ? OP_SB : (pick == 1 ? OP_SH : OP_SW);
            off     = 10'(drv_rand(256) * 4 + (pick == 0 ? drv_rand(4) : pick == 1 ? 2 : 0));
            hi      = drv_word();
            m.addr  = {hi[31:10], off};
            run_op(m, EXC_NONE);
            img[off[9:2]] = store_merge(img[off[9:2]], m.op, off[1:0], m.sdata);
            m.op   = OP_LW;
            m.addr = {m.addr[31:2], 2'b00};
            m.pc   = m.pc + 32'd4;
            run_op(m, EXC_NONE);
        end

        cur_test = "misaligned";
        for (int i = 0; i < N_MIS; i++) begin
            m       = '0;
            m.valid = 1'b1;
            m.wreg  = 1'b1;
            m.wd    = 5'd9;
            m.sdata = drv_word();
            hi      = drv_word();
            case (i % 4)
                0:       m.op = OP_LH;
                1:       m.op = OP_LW;
                2:       m.op = OP_SH;
                default: m.op = OP_SW;
            endcase
            m.addr = {hi[31:2], (m.op == OP_LW || m.op == OP_SW) ? 2'(1 + i % 3) : 2'b01};
            run_op(m, is_store(m.op) ? EXC_ADES : EXC_ADEL);
        end

        cur_test = "exception_priority";
        for (int i = 0; i < N_PRIO; i++) begin
            m       = '0;
            m.valid = (i % 8) != 7;
            m.exc   = 6'(drv_rand(64));
            pick    = drv_rand(3);
            m.op    = pick == 0 ? OP_NONE : (pick == 1 ? OP_LH : OP_SW);
            m.addr  = 32'h0000_0101;
            run_op(m, exc_expect(m, 1'b0));
        end

        cur_test    = "back_pressure";
        force_delay = SLOW;
        m           = '0;
        m.valid     = 1'b1;
        m.wreg      = 1'b1;
        m.wd        = 5'd17;
        m.op        = OP_LW;
        m.addr      = 32'h0000_0124;
        run_op(m, EXC_NONE, 2 * SLOW);
        m.op    = OP_SH;
        m.addr  = 32'h0000_0202;
        m.sdata = 32'h1234_abcd;
        run_op(m, EXC_NONE, 2 * SLOW);
        img[m.addr[9:2]] = store_merge(img[m.addr[9:2]], OP_SH, 2'b10, m.sdata);
        force_delay = 0;

        cur_test = "interrupt";
        @(negedge clk);
        // the finished store must not be issued a second time
        mem_in       = '0;
        hw_int       = 6'b000001;
        nop          = '0;
        nop.valid    = 1'b1;
        m            = '0;
        m.valid      = 1'b1;
        m.cp0.we     = 1'b1;
        m.cp0.addr   = CP0_STATUS;
        m.cp0.data   = 32'h0000_0401;
        run_op(m, EXC_NONE);
        // status write sits in wb_o, seen through forwarding
        run_op(nop, exc_expect(nop, 1'b1));
        run_op(nop, exc_expect(nop, 1'b1));
        m.cp0.addr = CP0_EPC;
        m.cp0.data = 32'hbfc0_0380;
        run_op(m, EXC_INT);
        run_op(nop, EXC_INT, 0, 1'b1, 32'hbfc0_0380);
        run_op(nop, EXC_INT, 0, 1'b1, 32'hbfc0_0380);

        @(negedge clk);
        mem_in = '0;
        repeat (4) @(posedge clk);
        if (n_checked != exp_q.size()) begin
            $display("error: %0d load results never reached write-back",
                     exp_q.size() - n_checked);
            stop_run();
        end else begin
            $display("TEST OK");
            $finish;
        end
    end

endmodule

/* dv/mips_mem_sva.sv */
`timescale 1ns/1ps

module mips_mem_sva
    import mips_mem_pkg::*;
(
    input logic     clk,
    input logic     rst,
    input bus_req_t bus_req_i,
    input bus_rsp_t bus_rsp_i,
    input logic     stall_i
);

    logic data_pend;

    // address accepted, data still owed
    always_ff @(posedge clk) begin
        if (rst) begin
            data_pend <= 1'b0;
        end else if (bus_rsp_i.data_ok) begin
            data_pend <= 1'b0;
        end else if (bus_req_i.req && bus_rsp_i.addr_ok) begin
            data_pend <= 1'b1;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (rst)
        bus_req_i.req && !bus_rsp_i.addr_ok |=> bus_req_i.req && $stable(bus_req_i))
        else $error("bus request dropped or changed before addr_ok");

    no_req_in_data: assert property (@(posedge clk) disable iff (rst)
        data_pend |-> !bus_req_i.req)
        else $error("new bus request while waiting for data");

    // from the request through the data wait, until data_ok
    stall_while_busy: assert property (@(posedge clk) disable iff (rst)
        (bus_req_i.req || data_pend) && !bus_rsp_i.data_ok |-> stall_i)
        else $error("transfer in flight without stall");

endmodule

/* rtl/mips_mem_top.sv */
`timescale 1ns/1ps

module mips_mem_top
    import mips_mem_pkg::*;
#(
    parameter int PHYS_ADDR_W = PHYS_ADDR_W_DEF
) (
    input  logic        clk,
    input  logic        rst,
    input  mem_in_t     mem_in_i,
    input  bus_rsp_t    bus_rsp_i,
    input  logic [5:0]  hw_int_i,
    output bus_req_t    bus_req_o,
    output wb_t         wb_o,
    output logic        stall_o,
    output exc_code_e   exc_code_o,
    output logic [31:0] epc_o
);

    wb_t       mem_wb;
    logic      misaligned;
    cp0_view_t cp0_view;

    mem_access_ctrl #(
        .PHYS_ADDR_W (PHYS_ADDR_W)
    ) i_mem_access_ctrl (
        .clk          (clk),
        .rst          (rst),
        .mem_in_i     (mem_in_i),
        .bus_rsp_i    (bus_rsp_i),
        .bus_req_o    (bus_req_o),
        .stall_o      (stall_o),
        .misaligned_o (misaligned),
        .mem_wb_o     (mem_wb)
    );

    except_arbiter i_except_arbiter (
        .rst          (rst),
        .mem_in_i     (mem_in_i),
        .misaligned_i (misaligned),
        .cp0_i        (cp0_view),
        .wb_cp0_i     (wb_o.cp0),
        .exc_code_o   (exc_code_o),
        .epc_o        (epc_o)
    );

    mem_wb_reg i_mem_wb_reg (
        .clk     (clk),
        .rst     (rst),
        .stall_i (stall_o),
        .d_i     (mem_wb),
        .q_o     (wb_o)
    );

    cp0_regs i_cp0_regs (
        .clk      (clk),
        .rst      (rst),
        .wr_i     (wb_o.cp0),
        .hw_int_i (hw_int_i),
        .cp0_o    (cp0_view)
    );

endmodule

/* rtl/mem_access_ctrl.sv */
`timescale 1ns/1ps

module mem_access_ctrl
    import mips_mem_pkg::*;
#(
    parameter int PHYS_ADDR_W = PHYS_ADDR_W_DEF
) (
    input  logic     clk,
    input  logic     rst,
    input  mem_in_t  mem_in_i,
    input  bus_rsp_t bus_rsp_i,
    output bus_req_t bus_req_o,
    output logic     stall_o,
    output logic     misaligned_o,
    output wb_t      mem_wb_o
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT_ADDR,
        S_WAIT_DATA
    } state_e;

    state_e      state_q;

    logic        is_mem;
    logic        is_wr;
    logic [1:0]  size;
    logic        bad_align;
    logic        start;
    logic        busy;
    logic [31:0] phys_addr;
    logic [31:0] lane_data;

    // transfer context kept while upstream holds
    mem_op_e     saved_op;
    logic [1:0]  saved_addr_lo;
    logic [4:0]  saved_wd;
    logic        saved_wr;

    mem_op_e     res_op;
    logic [1:0]  res_addr_lo;
    logic [4:0]  res_wd;
    logic        res_wr;
    logic [7:0]  rd_byte;
    logic [15:0] rd_half;
    logic [31:0] load_data;

    // no MMU, keep the low bits only
    assign phys_addr = 32'(mem_in_i.addr[PHYS_ADDR_W-1:0]);

    always_comb begin
        is_mem    = 1'b1;
        is_wr     = 1'b0;
        size      = 2'd0;
        bad_align = 1'b0;
        case (mem_in_i.op)
            OP_LB, OP_LBU: begin
                size = 2'd0;
            end
            OP_LH, OP_LHU: begin
                size      = 2'd1;
                bad_align = mem_in_i.addr[0];
            end
            OP_LW: begin
                size      = 2'd2;
                bad_align = |mem_in_i.addr[1:0];
            end
            OP_SB: begin
                is_wr = 1'b1;
            end
            OP_SH: begin
                is_wr     = 1'b1;
                size      = 2'd1;
                bad_align = mem_in_i.addr[0];
            end
            OP_SW: begin
                is_wr     = 1'b1;
                size      = 2'd2;
                bad_align = |mem_in_i.addr[1:0];
            end
            default: begin
                is_mem = 1'b0;
            end
        endcase
    end

    // store data on every byte lane
    always_comb begin
        case (size)
            2'd0:    lane_data = {4{mem_in_i.sdata[7:0]}};
            2'd1:    lane_data = {2{mem_in_i.sdata[15:0]}};
            default: lane_data = mem_in_i.sdata;
        endcase
    end

    assign misaligned_o = mem_in_i.valid && is_mem && bad_align;
    assign start        = (state_q == S_IDLE) && mem_in_i.valid && is_mem && !bad_align;
    assign busy         = start || (state_q != S_IDLE);
    assign stall_o      = busy && !bus_rsp_i.data_ok;

    always_comb begin
        bus_req_o.req   = start || (state_q == S_WAIT_ADDR);
        bus_req_o.wr    = is_wr;
        bus_req_o.size  = size;
        bus_req_o.addr  = phys_addr;
        bus_req_o.wdata = lane_data;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (start && !bus_rsp_i.addr_ok) begin
                        state_q <= S_WAIT_ADDR;
                    end else if (start && !bus_rsp_i.data_ok) begin
                        state_q <= S_WAIT_DATA;
                    end
                end
                S_WAIT_ADDR: begin
                    if (bus_rsp_i.addr_ok && bus_rsp_i.data_ok) begin
                        state_q <= S_IDLE;
                    end else if (bus_rsp_i.addr_ok) begin
                        state_q <= S_WAIT_DATA;
                    end
                end
                S_WAIT_DATA: begin
                    if (bus_rsp_i.data_ok) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            saved_op      <= mem_in_i.op;
            saved_addr_lo <= phys_addr[1:0];
            saved_wd      <= mem_in_i.wd;
            saved_wr      <= is_wr;
        end
    end

    // data_ok may come in the request cycle itself
    assign res_op      = (state_q == S_IDLE) ? mem_in_i.op : saved_op;
    assign res_addr_lo = (state_q == S_IDLE) ? phys_addr[1:0] : saved_addr_lo;
    assign res_wd      = (state_q == S_IDLE) ? mem_in_i.wd : saved_wd;
    assign res_wr      = (state_q == S_IDLE) ? is_wr : saved_wr;

    assign rd_byte = bus_rsp_i.rdata[{res_addr_lo, 3'b000} +: 8];
    assign rd_half = res_addr_lo[1] ? bus_rsp_i.rdata[31:16] : bus_rsp_i.rdata[15:0];

    always_comb begin
        case (res_op)
            OP_LB:   load_data = {{24{rd_byte[7]}}, rd_byte};
            OP_LBU:  load_data = {24'd0, rd_byte};
            OP_LH:   load_data = {{16{rd_half[15]}}, rd_half};
            OP_LHU:  load_data = {16'd0, rd_half};
            default: load_data = bus_rsp_i.rdata;
        endcase
    end

    always_comb begin
        mem_wb_o.cp0    = mem_in_i.cp0;
        mem_wb_o.cp0.we = mem_in_i.valid && mem_in_i.cp0.we;
        mem_wb_o.pc     = mem_in_i.pc;
        if (busy) begin
            mem_wb_o.wreg  = bus_rsp_i.data_ok && !res_wr;
            mem_wb_o.wd    = res_wd;
            mem_wb_o.wdata = load_data;
        end else begin
            mem_wb_o.wreg  = mem_in_i.valid && mem_in_i.wreg && !misaligned_o;
            mem_wb_o.wd    = mem_in_i.wd;
            mem_wb_o.wdata = mem_in_i.wdata;
        end
    end

endmodule

/* rtl/except_arbiter.sv */
`timescale 1ns/1ps

module except_arbiter
    import mips_mem_pkg::*;
(
    input  logic      rst,
    input  mem_in_t   mem_in_i,
    input  logic      misaligned_i,
    input  cp0_view_t cp0_i,
    input  cp0_wr_t   wb_cp0_i,
    output exc_code_e exc_code_o,
    output logic [31:0] epc_o
);

    logic        wb_live;
    logic [31:0] status;
    logic [31:0] cause;
    logic        int_pend;
    logic        is_store;

    // wb register contents are not trusted until reset ends
    assign wb_live = wb_cp0_i.we && !rst;

    always_comb begin
        status = cp0_i.status;
        if (wb_live && wb_cp0_i.addr == CP0_STATUS) begin
            status = wb_cp0_i.data;
        end
    end

    always_comb begin
        epc_o = cp0_i.epc;
        if (wb_live && wb_cp0_i.addr == CP0_EPC) begin
            epc_o = wb_cp0_i.data;
        end
    end

    // only IP[1:0], WP and IV of cause are software writable
    always_comb begin
        cause = cp0_i.cause;
        if (wb_live && wb_cp0_i.addr == CP0_CAUSE) begin
            cause[9:8] = wb_cp0_i.data[9:8];
            cause[22]  = wb_cp0_i.data[22];
            cause[23]  = wb_cp0_i.data[23];
        end
    end

    assign int_pend = (|(cause[15:8] & status[15:8])) && !status[1] && status[0];
    assign is_store = mem_in_i.op inside {OP_SB, OP_SH, OP_SW};

    always_comb begin
        exc_code_o = EXC_NONE;
        if (!mem_in_i.valid) begin
            exc_code_o = EXC_NONE;
        end else if (int_pend) begin
            exc_code_o = EXC_INT;
        end else if (mem_in_i.exc.syscall) begin
            exc_code_o = EXC_SYS;
        end else if (mem_in_i.exc.brk) begin
            exc_code_o = EXC_BP;
        end else if (mem_in_i.exc.ri) begin
            exc_code_o = EXC_RI;
        end else if (mem_in_i.exc.ov) begin
            exc_code_o = EXC_OV;
        end else if (mem_in_i.exc.trap) begin
            exc_code_o = EXC_TR;
        end else if (misaligned_i) begin
            exc_code_o = is_store ? EXC_ADES : EXC_ADEL;
        end else if (mem_in_i.exc.eret) begin
            exc_code_o = EXC_ERET;
        end
    end

endmodule

/* rtl/mem_wb_reg.sv */
`timescale 1ns/1ps

module mem_wb_reg
    import mips_mem_pkg::*;
(
    input  logic clk,
    input  logic rst,
    input  logic stall_i,
    input  wb_t  d_i,
    output wb_t  q_o
);

    logic        wreg_q;
    logic        cp0_we_q;
    logic [4:0]  wd_q;
    logic [31:0] wdata_q;
    logic [4:0]  cp0_addr_q;
    logic [31:0] cp0_data_q;
    logic [31:0] pc_q;

    // write enables
    always_ff @(posedge clk) begin
        if (rst) begin
            wreg_q   <= 1'b0;
            cp0_we_q <= 1'b0;
        end else if (!stall_i) begin
            wreg_q   <= d_i.wreg;
            cp0_we_q <= d_i.cp0.we;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_i) begin
            wd_q       <= d_i.wd;
            wdata_q    <= d_i.wdata;
            cp0_addr_q <= d_i.cp0.addr;
            cp0_data_q <= d_i.cp0.data;
            pc_q       <= d_i.pc;
        end
    end

    assign q_o.wreg     = wreg_q;
    assign q_o.wd       = wd_q;
    assign q_o.wdata    = wdata_q;
    assign q_o.cp0.we   = cp0_we_q;
    assign q_o.cp0.addr = cp0_addr_q;
    assign q_o.cp0.data = cp0_data_q;
    assign q_o.pc       = pc_q;

endmodule

/* rtl/cp0_regs.sv */
`timescale 1ns/1ps

module cp0_regs
    import mips_mem_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  cp0_wr_t    wr_i,
    input  logic [5:0] hw_int_i,
    output cp0_view_t  cp0_o
);

    logic [31:0] status_q;
    logic [31:0] cause_q;
    logic [31:0] epc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
            cause_q  <= '0;
            epc_q    <= '0;
        end else begin
            // hardware lines land in IP[7:2]
            cause_q[15:10] <= hw_int_i;
            if (wr_i.we) begin
                case (wr_i.addr)
                    CP0_STATUS: begin
                        // IM, EXL, IE
                        status_q[15:8] <= wr_i.data[15:8];
                        status_q[1]    <= wr_i.data[1];
                        status_q[0]    <= wr_i.data[0];
                    end
                    CP0_CAUSE: begin
                        cause_q[9:8] <= wr_i.data[9:8];
                        cause_q[22]  <= wr_i.data[22];
                        cause_q[23]  <= wr_i.data[23];
                    end
                    CP0_EPC: begin
                        epc_q <= wr_i.data;
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    assign cp0_o.status = status_q;
    assign cp0_o.cause  = cause_q;
    assign cp0_o.epc    = epc_q;

endmodule

/* rtl/mips_mem_pkg.sv */
package mips_mem_pkg;

    // default width of the physical address window
    localparam int PHYS_ADDR_W_DEF = 29;

    localparam logic [4:0] CP0_STATUS = 5'd12;
    localparam logic [4:0] CP0_CAUSE  = 5'd13;
    localparam logic [4:0] CP0_EPC    = 5'd14;

    typedef enum logic [3:0] {
        OP_NONE,
        OP_LB,
        OP_LBU,
        OP_LH,
        OP_LHU,
        OP_LW,
        OP_SB,
        OP_SH,
        OP_SW
    } mem_op_e;

    typedef enum logic [4:0] {
        EXC_NONE = 5'h00,
        EXC_INT  = 5'h01,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a,
        EXC_OV   = 5'h0c,
        EXC_TR   = 5'h0d,
        EXC_ERET = 5'h0e
    } exc_code_e;

    // flags raised earlier in the pipe
    typedef struct packed {
        logic syscall;
        logic brk;
        logic ri;
        logic ov;
        logic trap;
        logic eret;
    } exc_flags_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  addr;
        logic [31:0] data;
    } cp0_wr_t;

    typedef struct packed {
        logic        valid;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] sdata;
        logic [4:0]  wd;
        logic        wreg;
        logic [31:0] wdata;
        cp0_wr_t     cp0;
        exc_flags_t  exc;
        logic [31:0] pc;
        logic        in_delayslot;
    } mem_in_t;

    typedef struct packed {
        logic        wreg;
        logic [4:0]  wd;
        logic [31:0] wdata;
        cp0_wr_t     cp0;
        logic [31:0] pc;
    } wb_t;

    typedef struct packed {
        logic        req;
        logic        wr;
        logic [1:0]  size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic        addr_ok;
        logic        data_ok;
    } bus_rsp_t;

    typedef struct packed {
        logic [31:0] status;
        logic [31:0] cause;
        logic [31:0] epc;
    } cp0_view_t;

endpackage
